//--- include/agu_consts.svh
// widths and counts for the data-side address stage
`ifndef AGU_CONSTS_SVH
`define AGU_CONSTS_SVH

// virtual address and 8 KB page split
`define AGU_VADDR_W 44
`define AGU_PAGE_W 13
`define AGU_VPN_W 31

// physical frame number, paddr is pfn plus page offset
`define AGU_PFN_W 31

// four-byte cache banks
`define AGU_BANKS 32

// data TLB, fully associative
`define AGU_TLB_ENTRIES 8

// op FIFO between issue and translate
`define AGU_FIFO_DEPTH 4

`endif

//--- design/mem_op_pkg.sv
// memory operation types carried from issue to translation
`include "agu_consts.svh"

package mem_op_pkg;

  // operand size class, same order as the bank rule uses
  typedef enum logic [2:0] {
    b1   = 3'd0,
    b2   = 3'd1,
    b4   = 3'd2,
    b8   = 3'd3,
    b10  = 3'd4,  // long double
    b16u = 3'd5,  // unaligned 128 bit
    b20  = 3'd6,  // fill/spill
    b16a = 3'd7   // aligned 128 bit
  } size_class_t;

  // operation attribute nibble
  typedef logic [3:0] attr_t;

  localparam int attr_km = 0;  // kernel mode, others reserved

  // operation as it leaves the issue stage
  typedef struct packed {
    logic [`AGU_VADDR_W-1:0] vaddr;
    logic [4:0]              sz;
    logic [4:0]              bank0;
    logic [8:0]              regno;
    logic                    st;
    attr_t                   attr;
    logic [`AGU_BANKS-1:0]   banks;
  } mem_op_t;

endpackage

//--- design/tlb_pkg.sv
// data TLB entry and page fault code types
`include "agu_consts.svh"

package tlb_pkg;

  typedef struct packed {
    logic                  valid;
    logic [`AGU_VPN_W-1:0] vpn;
    logic [`AGU_PFN_W-1:0] pfn;
    logic                  sys;  // kernel only
    logic                  na;   // not accessible
  } tlb_entry_t;

  typedef logic [7:0] fault_code_t;

  // fault code bit positions
  localparam int fault_na_bit  = 0;
  localparam int fault_sys_bit = 2;

endpackage

//--- design/agu_issue.sv
// issue stage, registers an accepted memory operation with its bank mask
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_issue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    except,
  input  logic                    stall,
  input  logic                    op_en,
  input  logic [`AGU_VADDR_W-1:0] op_vaddr,
  input  logic [4:0]              op_sz,
  input  logic [4:0]              op_bank0,
  input  logic [8:0]              op_regno,
  input  logic                    op_st,
  input  mem_op_pkg::attr_t       op_attr,
  output logic                    push,
  output mem_op_pkg::mem_op_t     push_op
);
  import mem_op_pkg::*;

  size_class_t               sz_class;
  logic [4:0]                nbytes;
  logic [4:0]                span;
  logic [2:0]                nbanks;
  logic [`AGU_BANKS-1:0]     run;
  logic [2*`AGU_BANKS-1:0]   run_rot;
  logic [`AGU_BANKS-1:0]     banks;
  logic                      accept;

  assign accept = op_en & ~stall & ~except;

  always_comb begin
    case (op_sz)
      5'd16:               sz_class = b1;
      5'd17:               sz_class = b2;
      5'd18:               sz_class = b4;
      5'd19:               sz_class = b8;
      5'd3:                sz_class = b10;
      5'd0, 5'd1, 5'd2:    sz_class = b16u;
      5'd12, 5'd13, 5'd14: sz_class = b16a;
      5'd4, 5'd5, 5'd6:    sz_class = b4;
      5'd8, 5'd9, 5'd10:   sz_class = b8;
      5'd15:               sz_class = b20;
      default:             sz_class = b8;  // 7 and 11 are 64 bit
    endcase
  end

  always_comb begin
    case (sz_class)
      b1:         nbytes = 5'd1;
      b2:         nbytes = 5'd2;
      b4:         nbytes = 5'd4;
      b8:         nbytes = 5'd8;
      b10:        nbytes = 5'd10;
      b16u, b16a: nbytes = 5'd16;
      default:    nbytes = 5'd20;
    endcase
  end

  // number of banks the byte run crosses
  assign span   = {3'b000, op_vaddr[1:0]} + nbytes;
  assign nbanks = (sz_class == b20) ? 3'd5 : 3'((span + 5'd3) >> 2);

  assign run     = (`AGU_BANKS'(1) << nbanks) - `AGU_BANKS'(1);
  assign run_rot = {{`AGU_BANKS{1'b0}}, run} << op_bank0;  // upper half is the wrap

  always_comb begin
    if (sz_class == b16a) begin
      banks = {{(`AGU_BANKS-8){1'b0}}, 8'hff} << {op_bank0[4:3], 3'b000};
    end else begin
      banks = run_rot[`AGU_BANKS-1:0] | run_rot[2*`AGU_BANKS-1:`AGU_BANKS];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || except) begin
      push <= 1'b0;
    end else begin
      push <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      push_op.vaddr <= op_vaddr;
      push_op.sz    <= op_sz;
      push_op.bank0 <= op_bank0;
      push_op.regno <= op_regno;
      push_op.st    <= op_st;
      push_op.attr  <= op_attr;
      push_op.banks <= banks;
    end
  end

endmodule

//--- design/op_fifo.sv
// small circular FIFO with flush, for any payload type
`timescale 1ns/1ps

module op_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       flush,
  input  logic       push,
  input  payload_t   push_data,
  input  logic       pop,
  output payload_t   head,
  output logic       empty,
  output logic [2:0] count
);
  localparam int aw = (depth > 1) ? $clog2(depth) : 1;

  payload_t      mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic          do_pop;

  // wraps at depth, not only at a power of two
  function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] p);
    if (p == aw'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign empty  = (count == 3'd0);
  assign head   = mem[rd_ptr];
  assign do_pop = pop & ~empty;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 3'd0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + 3'(push) - 3'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- design/agu_translate.sv
// translation stage, data TLB lookup, permission check and result registers
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_translate (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                except,
  input  logic                                bus_hold,
  input  logic                                empty,
  input  mem_op_pkg::mem_op_t                 head,
  input  logic                                tlb_wen,
  input  logic [2:0]                          tlb_windex,
  input  logic [`AGU_VPN_W-1:0]               tlb_wvpn,
  input  logic [`AGU_PFN_W-1:0]               tlb_wpfn,
  input  logic                                tlb_wsys,
  input  logic                                tlb_wna,
  output logic                                pop,
  output logic                                mop_en,
  output logic                                tlb_miss,
  output logic                                page_fault,
  output tlb_pkg::fault_code_t                fault_code,
  output logic [`AGU_PFN_W+`AGU_PAGE_W-1:0]   mop_paddr,
  output logic [`AGU_BANKS-1:0]               mop_banks,
  output logic [4:0]                          mop_sz,
  output logic                                mop_st,
  output logic [8:0]                          mop_regno
);
  import mem_op_pkg::*;
  import tlb_pkg::*;

  tlb_entry_t            tlb [`AGU_TLB_ENTRIES];
  tlb_entry_t            hit_entry;
  logic                  hit;
  logic [`AGU_VPN_W-1:0] vpn;
  logic                  km;
  fault_code_t           fault;

  assign vpn = head.vaddr[`AGU_VADDR_W-1:`AGU_PAGE_W];
  assign km  = head.attr[attr_km];
  assign pop = ~empty & ~bus_hold;  // head is always valid when not empty

  // fully associative compare, lowest matching index wins
  always_comb begin
    hit       = 1'b0;
    hit_entry = '0;
    for (int i = 0; i < `AGU_TLB_ENTRIES; i++) begin
      if (!hit && tlb[i].valid && tlb[i].vpn == vpn) begin
        hit       = 1'b1;
        hit_entry = tlb[i];
      end
    end
  end

  // na outranks the user-mode check on a sys page
  always_comb begin
    fault = '0;
    if (hit_entry.na) begin
      fault[fault_na_bit] = 1'b1;
    end else if (hit_entry.sys && !km) begin
      fault[fault_sys_bit] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `AGU_TLB_ENTRIES; i++) begin
        tlb[i].valid <= 1'b0;
      end
    end else if (tlb_wen) begin
      tlb[tlb_windex] <= tlb_entry_t'{
        valid: 1'b1,
        vpn:   tlb_wvpn,
        pfn:   tlb_wpfn,
        sys:   tlb_wsys,
        na:    tlb_wna
      };
    end
  end

  // one strobe per popped op
  always_ff @(posedge clk) begin
    if (rst || except) begin
      mop_en     <= 1'b0;
      tlb_miss   <= 1'b0;
      page_fault <= 1'b0;
    end else begin
      mop_en     <= pop & hit & (fault == '0);
      tlb_miss   <= pop & ~hit;
      page_fault <= pop & hit & (fault != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      mop_paddr  <= {hit_entry.pfn, head.vaddr[`AGU_PAGE_W-1:0]};
      mop_banks  <= head.banks;
      mop_sz     <= head.sz;
      mop_st     <= head.st;
      mop_regno  <= head.regno;
      fault_code <= fault;
    end
  end

endmodule

//--- design/agu_top.sv
// data-side address stage, issue register, op FIFO and TLB translation
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              except,
  input  logic                              bus_hold,
  input  logic                              op_en,
  input  logic [`AGU_VADDR_W-1:0]           op_vaddr,
  input  logic [4:0]                        op_sz,
  input  logic [4:0]                        op_bank0,
  input  logic [8:0]                        op_regno,
  input  logic                              op_st,
  input  mem_op_pkg::attr_t                 op_attr,
  output logic                              stall,
  input  logic                              tlb_wen,
  input  logic [2:0]                        tlb_windex,
  input  logic [`AGU_VPN_W-1:0]             tlb_wvpn,
  input  logic [`AGU_PFN_W-1:0]             tlb_wpfn,
  input  logic                              tlb_wsys,
  input  logic                              tlb_wna,
  output logic                              mop_en,
  output logic                              tlb_miss,
  output logic                              page_fault,
  output tlb_pkg::fault_code_t              fault_code,
  output logic [`AGU_PFN_W+`AGU_PAGE_W-1:0] mop_paddr,
  output logic [`AGU_BANKS-1:0]             mop_banks,
  output logic [4:0]                        mop_sz,
  output logic                              mop_st,
  output logic [8:0]                        mop_regno
);
  import mem_op_pkg::*;

  mem_op_t    push_op;
  mem_op_t    head;
  logic       push;
  logic       empty;
  logic       pop;
  logic [2:0] fifo_count;

  // one slot kept back for the op sitting in the issue register
  assign stall = (fifo_count >= 3'(`AGU_FIFO_DEPTH - 1));

  agu_issue i_issue (
    .clk      (clk),
    .rst      (rst),
    .except   (except),
    .stall    (stall),
    .op_en    (op_en),
    .op_vaddr (op_vaddr),
    .op_sz    (op_sz),
    .op_bank0 (op_bank0),
    .op_regno (op_regno),
    .op_st    (op_st),
    .op_attr  (op_attr),
    .push     (push),
    .push_op  (push_op)
  );

  op_fifo #(
    .payload_t (mem_op_t),
    .depth     (`AGU_FIFO_DEPTH)
  ) i_fifo (
    .clk       (clk),
    .rst       (rst),
    .flush     (except),
    .push      (push),
    .push_data (push_op),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .count     (fifo_count)
  );

  agu_translate i_translate (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .bus_hold   (bus_hold),
    .empty      (empty),
    .head       (head),
    .tlb_wen    (tlb_wen),
    .tlb_windex (tlb_windex),
    .tlb_wvpn   (tlb_wvpn),
    .tlb_wpfn   (tlb_wpfn),
    .tlb_wsys   (tlb_wsys),
    .tlb_wna    (tlb_wna),
    .pop        (pop),
    .mop_en     (mop_en),
    .tlb_miss   (tlb_miss),
    .page_fault (page_fault),
    .fault_code (fault_code),
    .mop_paddr  (mop_paddr),
    .mop_banks  (mop_banks),
    .mop_sz     (mop_sz),
    .mop_st     (mop_st),
    .mop_regno  (mop_regno)
  );

endmodule

//--- test/agu_assert.sv
// protocol assertions on the address stage top level
`timescale 1ns/1ps

module agu_assert (
  input logic clk,
  input logic rst,
  input logic op_en,
  input logic stall,
  input logic mop_en,
  input logic tlb_miss,
  input logic page_fault
);
  logic any_result;

  assign any_result = mop_en | tlb_miss | page_fault;

  a_one_result: assert property (@(posedge clk) disable iff (rst)
    $onehot0({mop_en, tlb_miss, page_fault}))
    else $error("more than one result strobe in a cycle");

  a_quiet_after_rst: assert property (@(posedge clk) rst |=> !any_result)
    else $error("result strobe in the cycle after reset");

  // driver must hold off while stalled
  a_no_op_in_stall: assert property (@(posedge clk) disable iff (rst) !(op_en && stall))
    else $error("op_en high while stall high");

endmodule

//--- test/agu_tb.sv
// testbench for the address stage, random ops checked against a reference model
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_tb;

  typedef struct packed {
    logic [2:0]                          kind;  // {page_fault, tlb_miss, mop_en}
    logic [`AGU_PFN_W+`AGU_PAGE_W-1:0]   paddr;
    logic [`AGU_BANKS-1:0]               banks;
    logic [4:0]                          sz;
    logic                                st;
    logic [8:0]                          regno;
    logic [7:0]                          fcode;
  } exp_t;

  logic                              clk;
  logic                              rst;
  logic                              except;
  logic                              bus_hold;
  logic                              op_en;
  logic [`AGU_VADDR_W-1:0]           op_vaddr;
  logic [4:0]                        op_sz;
  logic [4:0]                        op_bank0;
  logic [8:0]                        op_regno;
  logic                              op_st;
  logic [3:0]                        op_attr;
  logic                              stall;
  logic                              tlb_wen;
  logic [2:0]                        tlb_windex;
  logic [`AGU_VPN_W-1:0]             tlb_wvpn;
  logic [`AGU_PFN_W-1:0]             tlb_wpfn;
  logic                              tlb_wsys;
  logic                              tlb_wna;
  logic                              mop_en;
  logic                              tlb_miss;
  logic                              page_fault;
  logic [7:0]                        fault_code;
  logic [`AGU_PFN_W+`AGU_PAGE_W-1:0] mop_paddr;
  logic [`AGU_BANKS-1:0]             mop_banks;
  logic [4:0]                        mop_sz;
  logic                              mop_st;
  logic [8:0]                        mop_regno;

  logic [31:0]           lfsr;
  int                    errors;
  int                    checked;
  exp_t                  exp_q[$];
  exp_t                  head_exp;
  logic [`AGU_VPN_W-1:0] tb_vpn [`AGU_TLB_ENTRIES];
  logic [`AGU_PFN_W-1:0] tb_pfn [`AGU_TLB_ENTRIES];
  logic                  tb_sys [`AGU_TLB_ENTRIES];
  logic                  tb_na  [`AGU_TLB_ENTRIES];
  logic [`AGU_VPN_W-1:0] miss_vpn;
  int                    fifo_model;
  logic                  issue_model;

  agu_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .bus_hold   (bus_hold),
    .op_en      (op_en),
    .op_vaddr   (op_vaddr),
    .op_sz      (op_sz),
    .op_bank0   (op_bank0),
    .op_regno   (op_regno),
    .op_st      (op_st),
    .op_attr    (op_attr),
    .stall      (stall),
    .tlb_wen    (tlb_wen),
    .tlb_windex (tlb_windex),
    .tlb_wvpn   (tlb_wvpn),
    .tlb_wpfn   (tlb_wpfn),
    .tlb_wsys   (tlb_wsys),
    .tlb_wna    (tlb_wna),
    .mop_en     (mop_en),
    .tlb_miss   (tlb_miss),
    .page_fault (page_fault),
    .fault_code (fault_code),
    .mop_paddr  (mop_paddr),
    .mop_banks  (mop_banks),
    .mop_sz     (mop_sz),
    .mop_st     (mop_st),
    .mop_regno  (mop_regno)
  );

  bind agu_top agu_assert i_assert (
    .clk        (clk),
    .rst        (rst),
    .op_en      (op_en),
    .stall      (stall),
    .mop_en     (mop_en),
    .tlb_miss   (tlb_miss),
    .page_fault (page_fault)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("Results checked: %0d, errors: %0d", checked, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string why);
    $display("Timeout, %s", why);
    errors++;
  endtask

  // size table and bank rule, byte run from bank0 wrapping past 31
  function automatic logic [`AGU_BANKS-1:0] model_banks(input logic [4:0] sz,
      input logic [4:0] bank0, input logic [1:0] lo);
    logic [`AGU_BANKS-1:0] m;
    int                    nbytes;
    int                    n;
    m = '0;
    case (sz)
      5'd16:                                 nbytes = 1;
      5'd17:                                 nbytes = 2;
      5'd18, 5'd4, 5'd5, 5'd6:               nbytes = 4;
      5'd3:                                  nbytes = 10;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: nbytes = 16;
      5'd15:                                 nbytes = 20;
      default:                               nbytes = 8;
    endcase
    if (sz >= 5'd12 && sz <= 5'd14) begin
      for (int i = 0; i < 8; i++) begin
        m[{bank0[4:3], 3'(i)}] = 1'b1;  // aligned group of eight
      end
    end else begin
      n = (sz == 5'd15) ? 5 : (int'(lo) + nbytes + 3) / 4;
      for (int i = 0; i < n; i++) begin
        m[(int'(bank0) + i) % `AGU_BANKS] = 1'b1;
      end
    end
    return m;
  endfunction

  task automatic load_tlb();
    for (int i = 0; i < `AGU_TLB_ENTRIES; i++) begin
      @(negedge clk);
      tb_vpn[i]  = {28'(rand_bits(28)), 3'(i)};  // low bits keep vpns apart
      tb_pfn[i]  = `AGU_PFN_W'(rand_bits(`AGU_PFN_W));
      tb_sys[i]  = (i >= 6);
      tb_na[i]   = (i == 7);  // sys and na, na must win
      tlb_wen    = 1'b1;
      tlb_windex = 3'(i);
      tlb_wvpn   = tb_vpn[i];
      tlb_wpfn   = tb_pfn[i];
      tlb_wsys   = tb_sys[i];
      tlb_wna    = tb_na[i];
    end
    @(negedge clk);
    tlb_wen  = 1'b0;
    miss_vpn = tb_vpn[0] ^ {1'b1, 30'd0};
  endtask

  // drive one op at the current falling edge and queue its expected result
  task automatic send_op(input logic [`AGU_VPN_W-1:0] vpn, input logic km);
    exp_t e;
    int   hit;
    op_vaddr = {vpn, `AGU_PAGE_W'(rand_bits(`AGU_PAGE_W))};
    op_sz    = 5'(rand_bits(5));
    op_bank0 = 5'(rand_bits(5));
    op_regno = 9'(rand_bits(9));
    op_st    = 1'(rand_bits(1));
    op_attr  = {3'(rand_bits(3)), km};
    op_en    = 1'b1;
    hit = -1;
    for (int i = `AGU_TLB_ENTRIES - 1; i >= 0; i--) begin
      if (tb_vpn[i] == vpn) begin
        hit = i;
      end
    end
    e       = '0;
    e.regno = op_regno;
    e.sz    = op_sz;
    e.st    = op_st;
    e.banks = model_banks(op_sz, op_bank0, op_vaddr[1:0]);
    if (hit < 0) begin
      e.kind = 3'b010;
    end else if (tb_na[hit]) begin
      e.kind  = 3'b100;
      e.fcode = 8'h01;
    end else if (tb_sys[hit] && !km) begin
      e.kind  = 3'b100;
      e.fcode = 8'h04;
    end else begin
      e.kind  = 3'b001;
      e.paddr = {tb_pfn[hit], op_vaddr[`AGU_PAGE_W-1:0]};
    end
    exp_q.push_back(e);
  endtask

  function automatic logic [`AGU_VPN_W-1:0] pick_vpn(input logic hit_only);
    logic [3:0] r;
    r = 4'(rand_bits(4));
    if (hit_only) begin
      return tb_vpn[r % 6];  // plain pages only
    end
    if (r == 4'hf) begin
      return miss_vpn;
    end
    return tb_vpn[r[2:0]];
  endfunction

  task automatic traffic(input int cycles, input logic hold, input logic hit_only);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      bus_hold = hold ? 1'(rand_bits(1)) : 1'b0;
      if (!stall && rand_bits(2) != 0) begin
        send_op(pick_vpn(hit_only), 1'(rand_bits(1)));
      end else begin
        op_en = 1'b0;
      end
    end
  endtask

  task automatic wait_drain();
    @(negedge clk);
    op_en    = 1'b0;
    bus_hold = 1'b0;
    for (int n = 0; n < 100; n++) begin
      if (exp_q.size() == 0) begin
        return;
      end
      @(negedge clk);
    end
    report_timeout("results still pending after the drain");
    exp_q.delete();
  endtask

  task automatic flush_test();
    int n;
    traffic(8, 1'b1, 1'b0);
    @(negedge clk);
    op_en  = 1'b0;
    except = 1'b1;
    @(negedge clk);
    except   = 1'b0;
    bus_hold = 1'b0;
    exp_q.delete();  // everything accepted before the pulse is gone
    for (n = 0; n < 10 && stall; n++) begin
      @(negedge clk);
    end
    if (stall) begin
      report_timeout("stall still high after the flush");
    end
    traffic(60, 1'b0, 1'b0);
    wait_drain();
  endtask

  task automatic check_latency();
    int n;
    wait_drain();
    repeat (3) @(negedge clk);
    send_op(tb_vpn[1], 1'b0);
    @(negedge clk);
    op_en = 1'b0;
    n = 1;
    while (!(mop_en || tlb_miss || page_fault) && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!(mop_en || tlb_miss || page_fault)) begin
      report_timeout("no result for the single op");
    end else begin
      check_val(64'(n), 64'd3, "accept to result latency");
    end
  endtask

  // results come out in acceptance order
  always @(negedge clk) begin
    if (!rst && (mop_en || tlb_miss || page_fault)) begin
      checked++;
      if (exp_q.size() == 0) begin
        $display("A result strobe fired with no operation pending at %0t", $time);
        errors++;
      end else begin
        head_exp = exp_q.pop_front();
        check_val(64'({page_fault, tlb_miss, mop_en}), 64'(head_exp.kind), "result kind");
        check_val(64'(mop_regno), 64'(head_exp.regno), "mop_regno");
        if (head_exp.kind == 3'b001) begin
          check_val(64'(mop_paddr), 64'(head_exp.paddr), "mop_paddr");
          check_val(64'(mop_banks), 64'(head_exp.banks), "mop_banks");
          check_val(64'(mop_sz), 64'(head_exp.sz), "mop_sz");
          check_val(64'(mop_st), 64'(head_exp.st), "mop_st");
        end else if (head_exp.kind == 3'b100) begin
          check_val(64'(fault_code), 64'(head_exp.fcode), "fault_code");
        end
      end
    end
  end

  // occupancy of issue register and FIFO, stall once one slot is left
  always @(posedge clk) begin
    if (rst || except) begin
      fifo_model  <= 0;
      issue_model <= 1'b0;
    end else begin
      fifo_model  <= fifo_model + int'(issue_model) - int'(fifo_model > 0 && !bus_hold);
      issue_model <= op_en && (fifo_model < `AGU_FIFO_DEPTH - 1);
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      check_val(64'(stall), 64'(fifo_model >= `AGU_FIFO_DEPTH - 1), "stall");
    end
  end

  always @(posedge clk) begin
    if (!rst && op_en && stall) begin
      $display("op_en was high while stall was high at %0t", $time);
      errors++;
    end
  end

  initial begin
    lfsr       = 32'd78015;
    errors     = 0;
    checked    = 0;
    rst        = 1'b1;
    except     = 1'b0;
    bus_hold   = 1'b0;
    op_en      = 1'b0;
    op_vaddr   = '0;
    op_sz      = '0;
    op_bank0   = '0;
    op_regno   = '0;
    op_st      = 1'b0;
    op_attr    = '0;
    tlb_wen    = 1'b0;
    tlb_windex = '0;
    tlb_wvpn   = '0;
    tlb_wpfn   = '0;
    tlb_wsys   = 1'b0;
    tlb_wna    = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    load_tlb();
    traffic(300, 1'b0, 1'b1);  // bank masks on hit pages
    wait_drain();
    @(negedge clk);
    send_op(miss_vpn, 1'b0);
    @(negedge clk);
    send_op(tb_vpn[6], 1'b0);  // sys page, user mode
    @(negedge clk);
    send_op(tb_vpn[7], 1'b0);  // sys and na in user mode, na wins
    @(negedge clk);
    send_op(tb_vpn[6], 1'b1);  // sys page, kernel mode issues
    wait_drain();
    traffic(400, 1'b1, 1'b0);
    wait_drain();
    flush_test();
    check_latency();
    finish_run();
  end

endmodule

//--- sources.f
+incdir+include
design/mem_op_pkg.sv
design/tlb_pkg.sv
design/agu_issue.sv
design/op_fifo.sv
design/agu_translate.sv
design/agu_top.sv
test/agu_assert.sv
test/agu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the address stage testbench under Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module agu_tb -o agu_sim
./obj_dir/agu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -q "Some tests failed" sim.log; then
  echo "simulation reported errors"
  exit 1
fi
echo "simulation clean"
